/* byte_enabled_dual_port.sv */
// ***************************************
// True dual port RAM, one clock, byte writes
// Write first per port, registered output only
// Same-address writes from both ports are undefined
// ***************************************
`timescale 1ns/1ps

module byte_enabled_dual_port import scratch_pkg::*; (
  input  logic              i_clock,
  input  logic              i_reset_a,   // Clears output registers only
  // Port A
  input  logic              i_en_a,
  input  logic [NB_COL-1:0] i_we_a,
  input  logic [ADDR_W-1:0] i_addr_a,
  input  logic [DATA_W-1:0] i_wdata_a,
  input  logic              i_re_a,
  output logic [DATA_W-1:0] o_rdata_a,
  // Port B
  input  logic              i_en_b,
  input  logic [NB_COL-1:0] i_we_b,
  input  logic [ADDR_W-1:0] i_addr_b,
  input  logic [DATA_W-1:0] i_wdata_b,
  input  logic              i_re_b,
  output logic [DATA_W-1:0] o_rdata_b
);

  logic [DATA_W-1:0] mem [RAM_DEPTH];
  logic [DATA_W-1:0] ram_data_a;  // First read stage
  logic [DATA_W-1:0] ram_data_b;
  logic [DATA_W-1:0] dout_a;      // Output register
  logic [DATA_W-1:0] dout_b;

  // Array powers up at zero
  initial begin
    for (int k = 0; k < RAM_DEPTH; k++) begin
      mem[k] = '0;
    end
  end

  // Both ports in one process so the array has a single driver
  // Port B is applied last on a lane clash
  always_ff @(posedge i_clock) begin
    for (int i = 0; i < NB_COL; i++) begin
      if (i_en_a) begin
        if (i_we_a[i]) begin  // New lane data goes to array and read stage
          mem[i_addr_a][i*COL_WIDTH +: COL_WIDTH] <= i_wdata_a[i*COL_WIDTH +: COL_WIDTH];
          ram_data_a[i*COL_WIDTH +: COL_WIDTH]    <= i_wdata_a[i*COL_WIDTH +: COL_WIDTH];
        end else begin
          ram_data_a[i*COL_WIDTH +: COL_WIDTH] <= mem[i_addr_a][i*COL_WIDTH +: COL_WIDTH];
        end
      end
      if (i_en_b) begin
        if (i_we_b[i]) begin
          mem[i_addr_b][i*COL_WIDTH +: COL_WIDTH] <= i_wdata_b[i*COL_WIDTH +: COL_WIDTH];
          ram_data_b[i*COL_WIDTH +: COL_WIDTH]    <= i_wdata_b[i*COL_WIDTH +: COL_WIDTH];
        end else begin
          ram_data_b[i*COL_WIDTH +: COL_WIDTH] <= mem[i_addr_b][i*COL_WIDTH +: COL_WIDTH];
        end
      end
    end
  end

  // Second stage, loads only when the controller asks
  always_ff @(posedge i_clock) begin
    if (i_reset_a) begin
      dout_a <= '0;
    end else if (i_re_a) begin
      dout_a <= ram_data_a;
    end
  end

  always_ff @(posedge i_clock) begin
    if (i_reset_a) begin
      dout_b <= '0;
    end else if (i_re_b) begin
      dout_b <= ram_data_b;
    end
  end

  assign o_rdata_a = dout_a;
  assign o_rdata_b = dout_b;

  // Requesters must keep apart on the same word
  a_no_lane_clash: assert property (@(posedge i_clock) disable iff (i_reset_a)
    (i_en_a && i_en_b && (i_addr_a == i_addr_b)) |-> ((i_we_a & i_we_b) == '0))
    else $error("Both ports wrote the same byte lane of address %0h", i_addr_a);

endmodule

/* dual_port_scratchpad.sv */
// ***************************************
// Two requesters on one shared scratchpad
// Ports are independent, no arbitration
// Same-address same-cycle writes are undefined
// ***************************************
`timescale 1ns/1ps

module dual_port_scratchpad import scratch_pkg::*; (
  input  logic              i_clock,
  input  logic              i_reset_a,
  // Requester A
  input  logic              i_req_valid_a,
  input  logic              i_req_write_a,
  input  logic [ADDR_W-1:0] i_req_addr_a,
  input  logic [DATA_W-1:0] i_req_wdata_a,
  input  logic [NB_COL-1:0] i_req_be_a,
  output logic              o_req_ready_a,
  output logic              o_rsp_valid_a,
  output logic [DATA_W-1:0] o_rsp_rdata_a,
  input  logic              i_rsp_ready_a,
  // Requester B
  input  logic              i_req_valid_b,
  input  logic              i_req_write_b,
  input  logic [ADDR_W-1:0] i_req_addr_b,
  input  logic [DATA_W-1:0] i_req_wdata_b,
  input  logic [NB_COL-1:0] i_req_be_b,
  output logic              o_req_ready_b,
  output logic              o_rsp_valid_b,
  output logic [DATA_W-1:0] o_rsp_rdata_b,
  input  logic              i_rsp_ready_b
);

  // Controller to RAM, port A
  logic              ram_en_a;
  logic [NB_COL-1:0] ram_we_a;
  logic [ADDR_W-1:0] ram_addr_a;
  logic [DATA_W-1:0] ram_wdata_a;
  logic              ram_re_a;
  logic [DATA_W-1:0] ram_rdata_a;
  // Controller to RAM, port B
  logic              ram_en_b;
  logic [NB_COL-1:0] ram_we_b;
  logic [ADDR_W-1:0] ram_addr_b;
  logic [DATA_W-1:0] ram_wdata_b;
  logic              ram_re_b;
  logic [DATA_W-1:0] ram_rdata_b;

  port_ctrl u_port_a (
    .i_clock     (i_clock),
    .i_reset_a   (i_reset_a),
    .i_req_valid (i_req_valid_a),
    .i_req_write (i_req_write_a),
    .i_req_addr  (i_req_addr_a),
    .i_req_wdata (i_req_wdata_a),
    .i_req_be    (i_req_be_a),
    .o_req_ready (o_req_ready_a),
    .o_rsp_valid (o_rsp_valid_a),
    .o_rsp_rdata (o_rsp_rdata_a),
    .i_rsp_ready (i_rsp_ready_a),
    .o_ram_en    (ram_en_a),
    .o_ram_we    (ram_we_a),
    .o_ram_addr  (ram_addr_a),
    .o_ram_wdata (ram_wdata_a),
    .o_ram_re    (ram_re_a),
    .i_ram_rdata (ram_rdata_a)
  );

  port_ctrl u_port_b (
    .i_clock     (i_clock),
    .i_reset_a   (i_reset_a),
    .i_req_valid (i_req_valid_b),
    .i_req_write (i_req_write_b),
    .i_req_addr  (i_req_addr_b),
    .i_req_wdata (i_req_wdata_b),
    .i_req_be    (i_req_be_b),
    .o_req_ready (o_req_ready_b),
    .o_rsp_valid (o_rsp_valid_b),
    .o_rsp_rdata (o_rsp_rdata_b),
    .i_rsp_ready (i_rsp_ready_b),
    .o_ram_en    (ram_en_b),
    .o_ram_we    (ram_we_b),
    .o_ram_addr  (ram_addr_b),
    .o_ram_wdata (ram_wdata_b),
    .o_ram_re    (ram_re_b),
    .i_ram_rdata (ram_rdata_b)
  );

  // Shared array, reset clears its output registers only
  byte_enabled_dual_port u_ram (
    .i_clock   (i_clock),
    .i_reset_a (i_reset_a),
    .i_en_a    (ram_en_a),
    .i_we_a    (ram_we_a),
    .i_addr_a  (ram_addr_a),
    .i_wdata_a (ram_wdata_a),
    .i_re_a    (ram_re_a),
    .o_rdata_a (ram_rdata_a),
    .i_en_b    (ram_en_b),
    .i_we_b    (ram_we_b),
    .i_addr_b  (ram_addr_b),
    .i_wdata_b (ram_wdata_b),
    .i_re_b    (ram_re_b),
    .o_rdata_b (ram_rdata_b)
  );

endmodule

/* list.f */
scratch_pkg.sv
byte_enabled_dual_port.sv
port_ctrl.sv
dual_port_scratchpad.sv
tb_checker.sv
tb_scratchpad.sv

/* port_ctrl.sv */
// ***************************************
// Front end for one RAM port
// Ready depends on held credits only, never on valid
// Read responses come back in request order
// ***************************************
`timescale 1ns/1ps

module port_ctrl import scratch_pkg::*; (
  input  logic              i_clock,
  input  logic              i_reset_a,
  // Request channel
  input  logic              i_req_valid,
  input  logic              i_req_write,
  input  logic [ADDR_W-1:0] i_req_addr,
  input  logic [DATA_W-1:0] i_req_wdata,
  input  logic [NB_COL-1:0] i_req_be,
  output logic              o_req_ready,
  // Response channel
  output logic              o_rsp_valid,
  output logic [DATA_W-1:0] o_rsp_rdata,
  input  logic              i_rsp_ready,
  // RAM port
  output logic              o_ram_en,
  output logic [NB_COL-1:0] o_ram_we,
  output logic [ADDR_W-1:0] o_ram_addr,
  output logic [DATA_W-1:0] o_ram_wdata,
  output logic              o_ram_re,
  input  logic [DATA_W-1:0] i_ram_rdata
);

  logic                 req_acc;             // Request handshake this cycle
  logic                 rd_acc;
  logic [RD_LAT-1:0]    rd_mark;             // One bit per RAM stage
  logic                 push;                // RAM output holds a read word
  logic                 pop;                 // Response handshake
  logic [RSP_CNT_W-1:0] credit_cnt;          // Reads in pipe plus buffered
  logic [DATA_W-1:0]    rsp_mem [RSP_DEPTH];
  logic [RSP_PTR_W-1:0] wr_ptr;
  logic [RSP_PTR_W-1:0] rd_ptr;
  logic [RSP_CNT_W-1:0] fifo_cnt;

  assign o_req_ready = (credit_cnt < RSP_DEPTH);
  assign req_acc     = i_req_valid && o_req_ready;
  assign rd_acc      = req_acc && !i_req_write;

  // One cycle of enable per accepted request
  assign o_ram_en    = req_acc;
  assign o_ram_we    = i_req_write ? i_req_be : '0;  // Reads carry no lanes
  assign o_ram_addr  = i_req_addr;
  assign o_ram_wdata = i_req_wdata;

  // Load output register only for our reads
  assign o_ram_re = rd_mark[RD_LAT-2];
  assign push     = rd_mark[RD_LAT-1];
  assign pop      = o_rsp_valid && i_rsp_ready;

  // Markers follow each read through the RAM stages
  always_ff @(posedge i_clock) begin
    if (i_reset_a) begin
      rd_mark <= '0;
    end else begin
      rd_mark <= {rd_mark[RD_LAT-2:0], rd_acc};
    end
  end

  // Credit taken on read accept, returned on response transfer
  always_ff @(posedge i_clock) begin
    if (i_reset_a) begin
      credit_cnt <= '0;
    end else begin
      case ({rd_acc, pop})
        2'b10:   credit_cnt <= credit_cnt + RSP_CNT_W'(1);
        2'b01:   credit_cnt <= credit_cnt - RSP_CNT_W'(1);
        default: credit_cnt <= credit_cnt;
      endcase
    end
  end

  // Response FIFO control
  always_ff @(posedge i_clock) begin
    if (i_reset_a) begin
      wr_ptr   <= '0;
      rd_ptr   <= '0;
      fifo_cnt <= '0;
    end else begin
      if (push) wr_ptr <= wr_ptr + RSP_PTR_W'(1);
      if (pop)  rd_ptr <= rd_ptr + RSP_PTR_W'(1);
      case ({push, pop})
        2'b10:   fifo_cnt <= fifo_cnt + RSP_CNT_W'(1);
        2'b01:   fifo_cnt <= fifo_cnt - RSP_CNT_W'(1);
        default: fifo_cnt <= fifo_cnt;
      endcase
    end
  end

  // Payload storage
  always_ff @(posedge i_clock) begin
    if (push) begin
      rsp_mem[wr_ptr] <= i_ram_rdata;
    end
  end

  assign o_rsp_valid = (fifo_cnt != '0);
  assign o_rsp_rdata = rsp_mem[rd_ptr];

  // Credits keep the buffer from filling past its depth
  a_no_overflow: assert property (@(posedge i_clock) disable iff (i_reset_a)
    (push && !pop) |-> (fifo_cnt < RSP_DEPTH))
    else $error("Response FIFO overflow");

  // Held response must not change under back-pressure
  a_rsp_stable: assert property (@(posedge i_clock) disable iff (i_reset_a)
    (o_rsp_valid && !i_rsp_ready) |=> (o_rsp_valid && $stable(o_rsp_rdata)))
    else $error("Response changed while waiting for ready");

endmodule

/* run_sim.sh */
#!/bin/bash
# Build the scratchpad testbench with Verilator, run it, then scan the log
set -e
cd "$(dirname "$0")"

verilator --binary --assert -Wno-fatal -f list.f --top-module tb_scratchpad \
  -o sim_scratchpad

./obj_dir/sim_scratchpad > sim.log
cat sim.log

if grep -q "TEST FAIL" sim.log; then
  echo "Simulation reported a failure"
  exit 1
fi
echo "Simulation finished clean"

/* scratch_pkg.sv */
// ***************************************
// Shared sizes for the scratchpad
// Depth and response buffer depth must be powers of two
// RD_LAT is fixed by the registered RAM output
// ***************************************
package scratch_pkg;

  // Byte lanes
  localparam int NB_COL    = 4;
  localparam int COL_WIDTH = 8;
  localparam int DATA_W    = NB_COL * COL_WIDTH;  // Full word

  // Memory array
  localparam int RAM_DEPTH = 256;
  localparam int ADDR_W    = $clog2(RAM_DEPTH);

  // Enabled cycle to valid data in the output register
  localparam int RD_LAT    = 2;

  // Response buffer per port
  // Also the cap on reads in flight plus buffered responses
  localparam int RSP_DEPTH = 2;
  localparam int RSP_PTR_W = $clog2(RSP_DEPTH);      // FIFO pointer
  localparam int RSP_CNT_W = $clog2(RSP_DEPTH + 1);  // Counts 0..RSP_DEPTH

endpackage

/* tb_checker.sv */
// ***************************************
// Response checker for the scratchpad
// Assumes one payload bus shared by both ports
// Read rows carry their expected word on wdata
// ***************************************
`timescale 1ns/1ps

module tb_checker import scratch_pkg::*; #(
  parameter int NAME_W = 96
) (
  input  logic                   i_clock,
  input  logic                   i_reset_a,
  input  logic [1:0]             i_req_valid,  // Bit 0 is port A
  input  logic                   i_req_write,
  input  logic [ADDR_W-1:0]      i_req_addr,
  input  logic [DATA_W-1:0]      i_req_wdata,
  input  logic [NB_COL-1:0]      i_req_be,
  input  logic [1:0]             i_req_ready,
  input  logic [1:0]             i_rsp_valid,
  input  logic [1:0][DATA_W-1:0] i_rsp_rdata,
  input  logic [1:0]             i_rsp_ready,
  input  logic [NAME_W-1:0]      i_name,       // Row on the request bus
  output int                     o_data_errs,
  output int                     o_other_errs,
  output int                     o_pending
);

  logic [DATA_W-1:0] model [RAM_DEPTH] = '{default: '0};  // Starts at zero like the RAM
  logic [DATA_W-1:0] exp_q [2][$];   // Expected words, request order
  logic [NAME_W-1:0] name_q [2][$];
  int                rd_cnt [2] = '{0, 0};
  int                rsp_cnt [2] = '{0, 0};
  int                data_errs = 0;
  int                other_errs = 0;
  int                pending = 0;
  logic              was_reset = 1'b1;

  assign o_data_errs  = data_errs;
  assign o_other_errs = other_errs;
  assign o_pending    = pending;

  always @(posedge i_clock) begin
    logic [DATA_W-1:0] exp_word;
    logic [NAME_W-1:0] row_name;
    if (!i_reset_a) begin
      for (int p = 0; p < 2; p++) begin
        if (was_reset && (!i_req_ready[p] || i_rsp_valid[p])) begin
          other_errs++;
          $display("Port %s is not idle right after reset", p == 0 ? "A" : "B");
        end
        if (i_rsp_valid[p] && exp_q[p].size() == 0) begin  // Nothing was asked for
          other_errs++;
          $display("Port %s shows a response with no read outstanding", p == 0 ? "A" : "B");
        end else if (i_rsp_valid[p] && i_rsp_ready[p]) begin
          exp_word = exp_q[p].pop_front();
          row_name = name_q[p].pop_front();
          rsp_cnt[p]++;
          if (i_rsp_rdata[p] !== exp_word) begin
            data_errs++;
            $display("ERR %0s port %s expected %h actual %h", row_name,
                     p == 0 ? "A" : "B", exp_word, i_rsp_rdata[p]);
          end
        end
        if (i_req_valid[p] && i_req_ready[p] && !i_req_write) begin
          if (i_req_wdata != model[i_req_addr]) begin  // Table and model disagree
            other_errs++;
            $display("Row %0s expects %h but the memory model holds %h", i_name,
                     i_req_wdata, model[i_req_addr]);
          end
          exp_q[p].push_back(model[i_req_addr]);
          name_q[p].push_back(i_name);
          rd_cnt[p]++;
          if (rd_cnt[p] > rsp_cnt[p] + RSP_DEPTH) begin
            other_errs++;
            $display("Port %s took more reads than it has response slots", p == 0 ? "A" : "B");
          end
        end
      end
      // Writes land after same-edge reads, RAM reads see old contents
      for (int p = 0; p < 2; p++) begin
        if (i_req_valid[p] && i_req_ready[p] && i_req_write) begin
          for (int l = 0; l < NB_COL; l++) begin
            if (i_req_be[l]) begin
              model[i_req_addr][l*COL_WIDTH +: COL_WIDTH] = i_req_wdata[l*COL_WIDTH +: COL_WIDTH];
            end
          end
        end
      end
    end
    was_reset = i_reset_a;
    pending   = exp_q[0].size() + exp_q[1].size();
  end

endmodule

/* tb_scratchpad.sv */
// ***************************************
// Testbench for the dual-port scratchpad
// Both ports share one payload bus, valids differ
// Rows never write one address from both ports
// ***************************************
`timescale 1ns/1ps

module tb_scratchpad import scratch_pkg::*; ();

  localparam int          N_ROWS    = 15;
  localparam int          BURST_ROW = 11;      // First of the back-to-back reads
  localparam int          NAME_W    = 8 * 12;  // Twelve characters
  localparam int          TIMEOUT   = 200;     // Cycles allowed per wait
  localparam logic [15:0] SEED      = 16'd31;

  logic                   i_clock = 1'b0;
  logic                   i_reset_a = 1'b1;
  logic [1:0]             i_req_valid = 2'b00;  // Bit 0 is port A
  logic                   i_req_write = 1'b0;
  logic [ADDR_W-1:0]      i_req_addr = '0;
  logic [DATA_W-1:0]      i_req_wdata = '0;
  logic [NB_COL-1:0]      i_req_be = '0;
  logic [1:0]             i_rsp_ready = 2'b00;
  logic [NAME_W-1:0]      i_name = '0;
  wire  [1:0]             o_req_ready;
  wire  [1:0]             o_rsp_valid;
  wire  [1:0][DATA_W-1:0] o_rsp_rdata;
  int                     o_data_errs;
  int                     o_other_errs;
  int                     o_pending;
  int                     timeouts = 0;
  logic [15:0]            rdy_state = SEED;  // Response ready LFSR
  logic [15:0]            gap_state = SEED;  // Request spacing LFSR

  // Port mask (1 A, 2 B, 3 both), write, address, data or expected word, byte mask
  logic [2+1+ADDR_W+DATA_W+NB_COL-1:0] rows [N_ROWS] = '{
    {2'd3, 1'b0, 8'h10, 32'h0000_0000, 4'h0},
    {2'd1, 1'b1, 8'h20, 32'hdead_beef, 4'hf},
    {2'd1, 1'b0, 8'h20, 32'hdead_beef, 4'h0},
    {2'd1, 1'b1, 8'h20, 32'h1122_3344, 4'h1},  // Lane 0 only
    {2'd2, 1'b1, 8'h20, 32'haabb_ccdd, 4'h4},  // Lane 2 only
    {2'd2, 1'b0, 8'h20, 32'hdebb_be44, 4'h0},
    {2'd1, 1'b1, 8'h30, 32'h0123_4567, 4'hf},
    {2'd2, 1'b0, 8'h30, 32'h0123_4567, 4'h0},
    {2'd2, 1'b1, 8'h31, 32'h89ab_cdef, 4'hf},
    {2'd1, 1'b0, 8'h31, 32'h89ab_cdef, 4'h0},
    {2'd2, 1'b1, 8'h40, 32'h1234_5678, 4'h6},  // Middle lanes
    {2'd3, 1'b0, 8'h40, 32'h0034_5600, 4'h0},
    {2'd3, 1'b0, 8'h20, 32'hdebb_be44, 4'h0},
    {2'd3, 1'b0, 8'h30, 32'h0123_4567, 4'h0},
    {2'd3, 1'b0, 8'h31, 32'h89ab_cdef, 4'h0}
  };
  logic [NAME_W-1:0] row_names [N_ROWS] = '{
    "rd_zero", "wr_full_a", "rd_full_a", "wr_lane0_a", "wr_lane2_b",
    "rd_mask_b", "wr_a_for_b", "rd_b_from_a", "wr_b_for_a", "rd_a_from_b",
    "wr_mid_b", "burst_0", "burst_1", "burst_2", "burst_3"
  };

  dual_port_scratchpad i_dut (
    .i_clock       (i_clock),
    .i_reset_a     (i_reset_a),
    .i_req_valid_a (i_req_valid[0]),
    .i_req_write_a (i_req_write),
    .i_req_addr_a  (i_req_addr),
    .i_req_wdata_a (i_req_wdata),
    .i_req_be_a    (i_req_be),
    .o_req_ready_a (o_req_ready[0]),
    .o_rsp_valid_a (o_rsp_valid[0]),
    .o_rsp_rdata_a (o_rsp_rdata[0]),
    .i_rsp_ready_a (i_rsp_ready[0]),
    .i_req_valid_b (i_req_valid[1]),
    .i_req_write_b (i_req_write),
    .i_req_addr_b  (i_req_addr),
    .i_req_wdata_b (i_req_wdata),
    .i_req_be_b    (i_req_be),
    .o_req_ready_b (o_req_ready[1]),
    .o_rsp_valid_b (o_rsp_valid[1]),
    .o_rsp_rdata_b (o_rsp_rdata[1]),
    .i_rsp_ready_b (i_rsp_ready[1])
  );

  tb_checker #(.NAME_W(NAME_W)) u_check (
    .*,
    .i_req_ready (o_req_ready),
    .i_rsp_valid (o_rsp_valid),
    .i_rsp_rdata (o_rsp_rdata)
  );

  always #10 i_clock = ~i_clock;  // 20 ns period

  // Galois form, x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
  endfunction

  // One fresh ready bit per port each cycle
  always @(posedge i_clock) begin
    logic [15:0] s1;
    logic [15:0] s2;
    s1 = lfsr_next(rdy_state);
    s2 = lfsr_next(s1);
    i_rsp_ready <= {s2[0], s1[0]};
    rdy_state = s2;
  end

  // Holds a row on the bus until every addressed port has taken it
  task automatic apply_row(input int r);
    logic [1:0]        port;
    logic              wr;
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] data;
    logic [NB_COL-1:0] be;
    int                wait_cnt;
    {port, wr, addr, data, be} = rows[r];
    i_req_valid <= port;
    i_req_write <= wr;
    i_req_addr  <= addr;
    i_req_wdata <= data;
    i_req_be    <= be;
    i_name      <= row_names[r];
    wait_cnt = 0;
    while (port != 2'b00 && wait_cnt < TIMEOUT) begin
      @(posedge i_clock);
      port = port & ~o_req_ready;  // Drop the ports that took it
      i_req_valid <= port;
      wait_cnt++;
    end
    if (port != 2'b00) begin
      timeouts++;
      $display("Row %0s was not accepted within %0d cycles", row_names[r], TIMEOUT);
      i_req_valid <= 2'b00;
    end
  endtask

  initial begin
    int gap;
    int wait_cnt;
    repeat (16) @(posedge i_clock);
    i_reset_a <= 1'b0;
    @(posedge i_clock);
    for (int r = 0; r < N_ROWS; r++) begin
      apply_row(r);
      gap = 0;
      if (r < BURST_ROW) begin  // Burst reads go out back to back to fill the slots
        repeat (2) begin  // Two bits give 0 to 3 idle cycles
          gap_state = lfsr_next(gap_state);
          gap = 2 * gap + int'(gap_state[0]);
        end
      end
      repeat (gap) @(posedge i_clock);
    end
    // Counts settle after the edge, so sample on the falling edge
    wait_cnt = 0;
    @(negedge i_clock);
    while (o_pending != 0 && wait_cnt < TIMEOUT) begin
      @(negedge i_clock);
      wait_cnt++;
    end
    if (o_pending != 0) begin
      timeouts++;
      $display("%0d read responses never arrived", o_pending);
    end
    // Any extra response still in the RAM stages shows up within this window
    repeat (RD_LAT + 1) @(negedge i_clock);
    $display("Errors: %0d data, %0d other, %0d timeouts", o_data_errs, o_other_errs, timeouts);
    if (o_data_errs + o_other_errs + timeouts == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule
